/* logic/fdsu_pkg.sv */
/*
  shared types and constants for the scalar divide / square-root unit
  operands are unsigned fixed point in [0,2): Q1.31 word, Q1.15 half
  every unit file refers to these by fdsu_pkg:: scoped names
*/
package fdsu_pkg;

//==========================================================
//  widths and constants
//==========================================================
localparam int DATA_W = 32;
localparam int HALF_W = 16;
localparam int EREG_W = 5;
localparam int VREG_W = 7;
localparam int IID_W  = 7;
localparam int CNT_W  = 6;
// partial remainder, wide enough for the sqrt trial of root plus 2 bits
localparam int REM_W  = DATA_W + 4;

// one in Q1.31 and Q1.15
localparam logic [DATA_W-1:0] ONE_WORD = 32'h8000_0000;
localparam logic [HALF_W-1:0] ONE_HALF = 16'h8000;

//==========================================================
//  encodings
//==========================================================
typedef enum logic [1:0] {
  OP_DIV   = 2'd0,
  OP_SQRT  = 2'd1,
  OP_RECIP = 2'd2
} fdsu_op_e;

typedef enum logic {
  W_WORD = 1'b0,
  W_HALF = 1'b1
} fdsu_width_e;

typedef enum logic [2:0] {
  ST_IDLE = 3'd0,
  ST_EX1  = 3'd1,
  ST_ITER = 3'd2,
  ST_PACK = 3'd3,
  ST_WB   = 3'd4
} fdsu_state_e;

//==========================================================
//  bundles
//==========================================================
typedef struct packed {
  fdsu_op_e    op;
  fdsu_width_e width;
} fdsu_func_t;

typedef struct packed {
  logic [EREG_W-1:0] dst_ereg;
  logic [VREG_W-1:0] dst_vreg;
  logic [IID_W-1:0]  iid;
} fdsu_tag_t;

// divide by zero, quotient >= 2, remainder not zero
typedef struct packed {
  logic dz;
  logic of;
  logic nx;
} fdsu_expt_t;

typedef struct packed {
  logic [DATA_W-1:0] data;
  fdsu_expt_t        expt;
  fdsu_tag_t         tag;
} fdsu_wb_t;

endpackage

/* logic/fdsu_ctrl.sv */
/*
  sequencer for one operation at a time
  issue -> EX1 -> N iteration steps -> pack (2 cycles) -> write-back pulse
  issue is accepted only while idle, busy covers the whole operation
*/
module fdsu_ctrl (
  input  logic                  ex1_data_clk,
  input  logic                  cpurst_b,
  input  logic                  issue_sel,
  input  fdsu_pkg::fdsu_width_e ex1_width,
  output logic                  busy,
  output logic                  ex1_pipedown,
  output logic                  iter_start,
  output logic                  iter_step,
  output logic                  ex3_pipedown,
  output logic                  wb_vld
);

fdsu_pkg::fdsu_state_e        state;
fdsu_pkg::fdsu_state_e        state_nxt;
logic [fdsu_pkg::CNT_W-1:0]   iter_cnt;
logic [fdsu_pkg::CNT_W-1:0]   iter_len;
logic                         issue_acc;

//==========================================================
//  state transitions
//==========================================================
// the only acceptance point for a new operation
assign issue_acc = issue_sel && (state == fdsu_pkg::ST_IDLE);

// one result bit per step
always_comb
begin
  if (ex1_width == fdsu_pkg::W_HALF)
    iter_len = fdsu_pkg::CNT_W'(fdsu_pkg::HALF_W);
  else
    iter_len = fdsu_pkg::CNT_W'(fdsu_pkg::DATA_W);
end

always_comb
begin
  state_nxt = state;
  case (state)
    fdsu_pkg::ST_IDLE: if (issue_acc) state_nxt = fdsu_pkg::ST_EX1;
    fdsu_pkg::ST_EX1:  state_nxt = fdsu_pkg::ST_ITER;
    // last step when one count is left
    fdsu_pkg::ST_ITER: if (iter_cnt == 1) state_nxt = fdsu_pkg::ST_PACK;
    // pack register, then tag into EX4
    fdsu_pkg::ST_PACK: if (iter_cnt == 0) state_nxt = fdsu_pkg::ST_WB;
    fdsu_pkg::ST_WB:   state_nxt = fdsu_pkg::ST_IDLE;
    default:           state_nxt = fdsu_pkg::ST_IDLE;
  endcase
end

always_ff @(posedge ex1_data_clk or negedge cpurst_b)
begin
  if (!cpurst_b)
  begin
    state    <= fdsu_pkg::ST_IDLE;
    iter_cnt <= '0;
  end
  else
  begin
    state <= state_nxt;
    case (state)
      fdsu_pkg::ST_EX1:  iter_cnt <= iter_len;
      // hold at one on exit so pack sees a first cycle
      fdsu_pkg::ST_ITER: iter_cnt <= (iter_cnt == 1) ? iter_cnt : iter_cnt - 1'b1;
      fdsu_pkg::ST_PACK: iter_cnt <= iter_cnt - 1'b1;
      default:           iter_cnt <= iter_cnt;
    endcase
  end
end

//==========================================================
//  strobes
//==========================================================
assign busy         = (state != fdsu_pkg::ST_IDLE);
assign ex1_pipedown = (state == fdsu_pkg::ST_EX1);
assign iter_start   = (state == fdsu_pkg::ST_EX1);
assign iter_step    = (state == fdsu_pkg::ST_ITER);
// first pack cycle only
assign ex3_pipedown = (state == fdsu_pkg::ST_PACK) && (iter_cnt == 1);
assign wb_vld       = (state == fdsu_pkg::ST_WB);

endmodule

/* logic/fdsu_scalar_dp.sv */
/*
  EX1 decode latch and operand select, plus the tag pipeline
  a reciprocal is issued onward as a divide of the constant one
  the tag rides alongside the data from EX1 to EX4 and drives write-back
*/
module fdsu_scalar_dp (
  input  logic                        ex1_data_clk,
  input  logic                        cpurst_b,
  input  logic                        issue_sel,
  input  logic                        busy,
  input  fdsu_pkg::fdsu_func_t        issue_func,
  input  logic [fdsu_pkg::DATA_W-1:0] src0,
  input  logic [fdsu_pkg::DATA_W-1:0] src1,
  input  fdsu_pkg::fdsu_tag_t         issue_tag,
  input  logic                        ex1_pipedown,
  input  logic                        ex3_pipedown,
  output fdsu_pkg::fdsu_width_e       ex1_width,
  output fdsu_pkg::fdsu_op_e          ex1_op,
  output logic [fdsu_pkg::DATA_W-1:0] ex1_src0,
  output logic [fdsu_pkg::DATA_W-1:0] ex1_src1,
  output fdsu_pkg::fdsu_tag_t         wb_tag
);

fdsu_pkg::fdsu_func_t          ex1_func;
fdsu_pkg::fdsu_tag_t           ex1_tag;
fdsu_pkg::fdsu_tag_t           ex2_tag;
fdsu_pkg::fdsu_tag_t           ex4_tag;
logic [fdsu_pkg::DATA_W-1:0]   ex1_opnd0;
logic [fdsu_pkg::DATA_W-1:0]   ex1_opnd1;
logic                          ex1_load;
logic                          ex1_recip;
logic                          ex4_pipedown;

//==========================================================
//  EX1 latch
//==========================================================
// load enable follows the ctrl acceptance
assign ex1_load = issue_sel && !busy;

always_ff @(posedge ex1_data_clk or negedge cpurst_b)
begin
  if (!cpurst_b)
  begin
    ex1_func <= '0;
    ex1_tag  <= '0;
  end
  else if (ex1_load)
  begin
    ex1_func <= issue_func;
    ex1_tag  <= issue_tag;
  end
end

// source operands
always_ff @(posedge ex1_data_clk)
begin
  if (ex1_load)
  begin
    ex1_opnd0 <= src0;
    ex1_opnd1 <= src1;
  end
end

//==========================================================
//  operand select
//==========================================================
assign ex1_recip = (ex1_func.op == fdsu_pkg::OP_RECIP);
assign ex1_width = ex1_func.width;

always_comb
begin
  if (ex1_recip)
  begin
    // 1 / x becomes one divided by src0
    ex1_op   = fdsu_pkg::OP_DIV;
    ex1_src1 = ex1_opnd0;
    if (ex1_func.width == fdsu_pkg::W_HALF)
      ex1_src0 = {{(fdsu_pkg::DATA_W-fdsu_pkg::HALF_W){1'b0}}, fdsu_pkg::ONE_HALF};
    else
      ex1_src0 = fdsu_pkg::ONE_WORD;
  end
  else
  begin
    ex1_op   = ex1_func.op;
    ex1_src0 = ex1_opnd0;
    ex1_src1 = ex1_opnd1;
  end
end

//==========================================================
//  tag pipeline
//==========================================================
always_ff @(posedge ex1_data_clk or negedge cpurst_b)
begin
  if (!cpurst_b)
  begin
    ex2_tag      <= '0;
    ex4_tag      <= '0;
    ex4_pipedown <= 1'b0;
  end
  else
  begin
    // ex3 strobe delayed one cycle moves the tag into EX4
    ex4_pipedown <= ex3_pipedown;
    if (ex1_pipedown)
      ex2_tag <= ex1_tag;
    if (ex4_pipedown)
      ex4_tag <= ex2_tag;
  end
end

assign wb_tag = ex4_tag;

endmodule

/* logic/fdsu_iter.sv */
/*
  bit-serial restoring iterator for divide and square root
  loads aligned operands on iter_start, one result bit per iter_step
  divide trial is the divisor, sqrt trial is the partial root with 01 appended
*/
module fdsu_iter (
  input  logic                        ex1_data_clk,
  input  logic                        cpurst_b,
  input  logic                        iter_start,
  input  logic                        iter_step,
  input  fdsu_pkg::fdsu_op_e          ex1_op,
  input  fdsu_pkg::fdsu_width_e       ex1_width,
  input  logic [fdsu_pkg::DATA_W-1:0] ex1_src0,
  input  logic [fdsu_pkg::DATA_W-1:0] ex1_src1,
  output logic [fdsu_pkg::DATA_W-1:0] iter_root,
  output logic                        iter_rem_nz,
  output logic                        iter_dz,
  output logic                        iter_of
);

logic                            iter_sqrt;
logic                            start_sqrt;
logic                            start_dz;
logic                            start_of;
logic [fdsu_pkg::DATA_W-1:0]     opa;
logic [fdsu_pkg::DATA_W-1:0]     opb;
logic [2*fdsu_pkg::DATA_W-1:0]   rad_init;
logic [2*fdsu_pkg::DATA_W-1:0]   rad;
logic [fdsu_pkg::DATA_W-1:0]     divisor;
logic [fdsu_pkg::DATA_W-1:0]     root;
logic [fdsu_pkg::REM_W-1:0]      rem;
logic [fdsu_pkg::REM_W-1:0]      rem_in;
logic [fdsu_pkg::REM_W-1:0]      trial;
logic [fdsu_pkg::REM_W:0]        diff;
logic [fdsu_pkg::REM_W-1:0]      rem_sel;
logic                            bit_ge;

//==========================================================
//  operand alignment at start
//==========================================================
always_comb
begin
  if (ex1_width == fdsu_pkg::W_HALF)
  begin
    opa = {{(fdsu_pkg::DATA_W-fdsu_pkg::HALF_W){1'b0}}, ex1_src0[fdsu_pkg::HALF_W-1:0]};
    opb = {{(fdsu_pkg::DATA_W-fdsu_pkg::HALF_W){1'b0}}, ex1_src1[fdsu_pkg::HALF_W-1:0]};
    // radicand a << 15, top aligned
    rad_init = {1'b0, ex1_src0[fdsu_pkg::HALF_W-1:0],
                {(2*fdsu_pkg::DATA_W-fdsu_pkg::HALF_W-1){1'b0}}};
  end
  else
  begin
    opa = ex1_src0;
    opb = ex1_src1;
    // radicand a << 31
    rad_init = {1'b0, ex1_src0, {(fdsu_pkg::DATA_W-1){1'b0}}};
  end
end

assign start_sqrt = (ex1_op == fdsu_pkg::OP_SQRT);
assign start_dz   = !start_sqrt && (opb == '0);
// quotient would need two integer bits
assign start_of   = !start_sqrt && (opb != '0) && ({1'b0, opa} >= {opb, 1'b0});

//==========================================================
//  one restoring step
//==========================================================
always_comb
begin
  if (iter_sqrt)
  begin
    rem_in = {rem[fdsu_pkg::REM_W-3:0], rad[2*fdsu_pkg::DATA_W-1 -: 2]};
    trial  = {{(fdsu_pkg::REM_W-fdsu_pkg::DATA_W-2){1'b0}}, root, 2'b01};
  end
  else
  begin
    rem_in = rem;
    trial  = {{(fdsu_pkg::REM_W-fdsu_pkg::DATA_W){1'b0}}, divisor};
  end
end

assign diff    = {1'b0, rem_in} - {1'b0, trial};
assign bit_ge  = !diff[fdsu_pkg::REM_W];
assign rem_sel = bit_ge ? diff[fdsu_pkg::REM_W-1:0] : rem_in;

always_ff @(posedge ex1_data_clk or negedge cpurst_b)
begin
  if (!cpurst_b)
  begin
    iter_sqrt <= 1'b0;
    iter_dz   <= 1'b0;
    iter_of   <= 1'b0;
  end
  else if (iter_start)
  begin
    iter_sqrt <= start_sqrt;
    iter_dz   <= start_dz;
    iter_of   <= start_of;
  end
end

always_ff @(posedge ex1_data_clk)
begin
  if (iter_start)
  begin
    divisor <= opb;
    rad     <= rad_init;
    root    <= '0;
    rem     <= start_sqrt ? '0 : {{(fdsu_pkg::REM_W-fdsu_pkg::DATA_W){1'b0}}, opa};
  end
  else if (iter_step)
  begin
    rad  <= {rad[2*fdsu_pkg::DATA_W-3:0], 2'b00};
    root <= {root[fdsu_pkg::DATA_W-2:0], bit_ge};
    // divide remainder doubles after each step
    rem  <= iter_sqrt ? rem_sel : {rem_sel[fdsu_pkg::REM_W-2:0], 1'b0};
  end
end

assign iter_root   = root;
assign iter_rem_nz = |rem;

endmodule

/* logic/fdsu_pack.sv */
/*
  result packing for write-back, registered on ex3_pipedown
  saturates on dz or of, boxes half results with ones, derives nx
*/
module fdsu_pack (
  input  logic                        ex1_data_clk,
  input  logic                        cpurst_b,
  input  logic                        ex3_pipedown,
  input  fdsu_pkg::fdsu_width_e       ex1_width,
  input  logic [fdsu_pkg::DATA_W-1:0] iter_root,
  input  logic                        iter_rem_nz,
  input  logic                        iter_dz,
  input  logic                        iter_of,
  output logic [fdsu_pkg::DATA_W-1:0] wb_data,
  output fdsu_pkg::fdsu_expt_t        wb_expt
);

logic                          pack_sat;
logic [fdsu_pkg::DATA_W-1:0]   pack_data;
fdsu_pkg::fdsu_expt_t          pack_expt;

//==========================================================
//  data and flags
//==========================================================
assign pack_sat = iter_dz | iter_of;

always_comb
begin
  if (pack_sat)
    pack_data = '1;
  else if (ex1_width == fdsu_pkg::W_HALF)
    pack_data = {{(fdsu_pkg::DATA_W-fdsu_pkg::HALF_W){1'b1}},
                 iter_root[fdsu_pkg::HALF_W-1:0]};
  else
    pack_data = iter_root;
end

// nx only for a real result
assign pack_expt.dz = iter_dz;
assign pack_expt.of = iter_of;
assign pack_expt.nx = iter_rem_nz & ~pack_sat;

always_ff @(posedge ex1_data_clk or negedge cpurst_b)
begin
  if (!cpurst_b)
    wb_expt <= '0;
  else if (ex3_pipedown)
    wb_expt <= pack_expt;
end

// held until the next operation packs
always_ff @(posedge ex1_data_clk)
begin
  if (ex3_pipedown)
    wb_data <= pack_data;
end

endmodule

/* logic/fdsu_top.sv */
/*
  top of the scalar divide / square-root slice
  strobe issue with busy level, one-cycle wb_vld with payload, no back-pressure
*/
module fdsu_top (
  input  logic                        ex1_data_clk,
  input  logic                        cpurst_b,
  input  logic                        issue_sel,
  input  fdsu_pkg::fdsu_func_t        issue_func,
  input  logic [fdsu_pkg::DATA_W-1:0] src0,
  input  logic [fdsu_pkg::DATA_W-1:0] src1,
  input  fdsu_pkg::fdsu_tag_t         issue_tag,
  output logic                        busy,
  output logic                        wb_vld,
  output fdsu_pkg::fdsu_wb_t          wb
);

// control strobes
logic                          ex1_pipedown;
logic                          iter_start;
logic                          iter_step;
logic                          ex3_pipedown;
// EX1 decode
fdsu_pkg::fdsu_width_e         ex1_width;
fdsu_pkg::fdsu_op_e            ex1_op;
logic [fdsu_pkg::DATA_W-1:0]   ex1_src0;
logic [fdsu_pkg::DATA_W-1:0]   ex1_src1;
// iterator results
logic [fdsu_pkg::DATA_W-1:0]   iter_root;
logic                          iter_rem_nz;
logic                          iter_dz;
logic                          iter_of;
// write-back pieces
logic [fdsu_pkg::DATA_W-1:0]   wb_data;
fdsu_pkg::fdsu_expt_t          wb_expt;
fdsu_pkg::fdsu_tag_t           wb_tag;

fdsu_ctrl u_fdsu_ctrl (
  .ex1_data_clk (ex1_data_clk),
  .cpurst_b     (cpurst_b),
  .issue_sel    (issue_sel),
  .ex1_width    (ex1_width),
  .busy         (busy),
  .ex1_pipedown (ex1_pipedown),
  .iter_start   (iter_start),
  .iter_step    (iter_step),
  .ex3_pipedown (ex3_pipedown),
  .wb_vld       (wb_vld)
);

fdsu_scalar_dp u_fdsu_scalar_dp (
  .ex1_data_clk (ex1_data_clk),
  .cpurst_b     (cpurst_b),
  .issue_sel    (issue_sel),
  .busy         (busy),
  .issue_func   (issue_func),
  .src0         (src0),
  .src1         (src1),
  .issue_tag    (issue_tag),
  .ex1_pipedown (ex1_pipedown),
  .ex3_pipedown (ex3_pipedown),
  .ex1_width    (ex1_width),
  .ex1_op       (ex1_op),
  .ex1_src0     (ex1_src0),
  .ex1_src1     (ex1_src1),
  .wb_tag       (wb_tag)
);

fdsu_iter u_fdsu_iter (
  .ex1_data_clk (ex1_data_clk),
  .cpurst_b     (cpurst_b),
  .iter_start   (iter_start),
  .iter_step    (iter_step),
  .ex1_op       (ex1_op),
  .ex1_width    (ex1_width),
  .ex1_src0     (ex1_src0),
  .ex1_src1     (ex1_src1),
  .iter_root    (iter_root),
  .iter_rem_nz  (iter_rem_nz),
  .iter_dz      (iter_dz),
  .iter_of      (iter_of)
);

fdsu_pack u_fdsu_pack (
  .ex1_data_clk (ex1_data_clk),
  .cpurst_b     (cpurst_b),
  .ex3_pipedown (ex3_pipedown),
  .ex1_width    (ex1_width),
  .iter_root    (iter_root),
  .iter_rem_nz  (iter_rem_nz),
  .iter_dz      (iter_dz),
  .iter_of      (iter_of),
  .wb_data      (wb_data),
  .wb_expt      (wb_expt)
);

// write-back payload
assign wb.data = wb_data;
assign wb.expt = wb_expt;
assign wb.tag  = wb_tag;

endmodule

/* verification/tb_fdsu.sv */
/*
  testbench for the scalar divide / square-root unit
  seeded random divides, square roots and reciprocals against a reference model
  also checks latency, tags, busy, ignored issue while busy and the pulse count
*/
module tb_fdsu;
timeunit 1ns;
timeprecision 1ps;

localparam int NUM_OPS     = 300;
localparam int CYCLE_LIMIT = NUM_OPS * 40;

logic                        ex1_data_clk;
logic                        cpurst_b;
logic                        issue_sel;
fdsu_pkg::fdsu_func_t        issue_func;
logic [fdsu_pkg::DATA_W-1:0] src0;
logic [fdsu_pkg::DATA_W-1:0] src1;
fdsu_pkg::fdsu_tag_t         issue_tag;
logic                        busy;
logic                        wb_vld;
fdsu_pkg::fdsu_wb_t          wb;

logic [31:0]                 lcg_state = 32'h7555dcdf;
int                          cycle_cnt = 0;
int                          pulses    = 0;
int                          ops_done  = 0;

fdsu_top u_fdsu_top (
  .ex1_data_clk (ex1_data_clk),
  .cpurst_b     (cpurst_b),
  .issue_sel    (issue_sel),
  .issue_func   (issue_func),
  .src0         (src0),
  .src1         (src1),
  .issue_tag    (issue_tag),
  .busy         (busy),
  .wb_vld       (wb_vld),
  .wb           (wb)
);

//============================================================
//  clock, timeout, write-back pulse monitor
//============================================================
initial
begin
  ex1_data_clk = 1'b0;
  forever #10 ex1_data_clk = ~ex1_data_clk;
end

always @(posedge ex1_data_clk)
begin
  cycle_cnt <= cycle_cnt + 1;
  if (cycle_cnt >= CYCLE_LIMIT)
  begin
    $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
    abort_run();
  end
end

// count pulses mid-cycle where wb_vld is settled
always @(negedge ex1_data_clk)
begin
  if (wb_vld === 1'b1)
    pulses = pulses + 1;
end

//============================================================
//  helpers
//============================================================
task automatic abort_run();
  $display(">>> FAIL");
  $fatal(1);
endtask

function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic fdsu_pkg::fdsu_func_t random_func();
  fdsu_pkg::fdsu_func_t func;
  logic [31:0]          r;
  r = next_rand();
  case (r[31:16] % 16'd3)
    16'd0:   func.op = fdsu_pkg::OP_DIV;
    16'd1:   func.op = fdsu_pkg::OP_SQRT;
    default: func.op = fdsu_pkg::OP_RECIP;
  endcase
  func.width = r[12] ? fdsu_pkg::W_HALF : fdsu_pkg::W_WORD;
  return func;
endfunction

// bitwise integer square root
function automatic logic [63:0] int_sqrt(input logic [63:0] v);
  logic [63:0] root;
  logic [63:0] cand;
  root = '0;
  for (int i = 31; i >= 0; i--)
  begin
    cand = root | (64'd1 << i);
    if (cand * cand <= v)
      root = cand;
  end
  return root;
endfunction

//============================================================
//  reference model
//============================================================
function automatic fdsu_pkg::fdsu_wb_t model_result(
  input fdsu_pkg::fdsu_func_t func,
  input logic [31:0]          s0,
  input logic [31:0]          s1,
  input fdsu_pkg::fdsu_tag_t  tag
);
  fdsu_pkg::fdsu_wb_t res;
  logic [63:0]        a;
  logic [63:0]        b;
  logic [63:0]        q;
  logic [63:0]        r;
  logic               half;
  int                 f;
  half = (func.width == fdsu_pkg::W_HALF);
  f    = half ? 15 : 31;
  a    = half ? {48'd0, s0[15:0]} : {32'd0, s0};
  b    = half ? {48'd0, s1[15:0]} : {32'd0, s1};
  // reciprocal divides the one of the width by src0
  if (func.op == fdsu_pkg::OP_RECIP)
  begin
    b = a;
    a = 64'd1 << f;
  end
  res.tag  = tag;
  res.expt = '0;
  if (func.op == fdsu_pkg::OP_SQRT)
  begin
    q = int_sqrt(a << f);
    r = (a << f) - q * q;
  end
  else
  begin
    res.expt.dz = (b == 64'd0);
    res.expt.of = (b != 64'd0) && (a >= (b << 1));
    q = res.expt.dz ? 64'd0 : (a << f) / b;
    r = res.expt.dz ? 64'd0 : (a << f) % b;
  end
  if (res.expt.dz || res.expt.of)
    res.data = '1;
  else if (half)
    res.data = {16'hffff, q[15:0]};
  else
    res.data = q[31:0];
  res.expt.nx = (r != 64'd0) && !res.expt.dz && !res.expt.of;
  return res;
endfunction

//============================================================
//  compare tasks
//============================================================
task automatic check_data(input logic [fdsu_pkg::DATA_W-1:0] got,
                          input logic [fdsu_pkg::DATA_W-1:0] exp);
  if (got !== exp)
  begin
    $display("Fail wb.data got %h expected %h", got, exp);
    abort_run();
  end
endtask

task automatic check_expt(input fdsu_pkg::fdsu_expt_t got, input fdsu_pkg::fdsu_expt_t exp);
  if (got !== exp)
  begin
    $display("Fail wb.expt {dz,of,nx} got %h expected %h", got, exp);
    abort_run();
  end
endtask

task automatic check_tag(input fdsu_pkg::fdsu_tag_t got, input fdsu_pkg::fdsu_tag_t exp);
  if (got !== exp)
  begin
    $display("Fail wb.tag got %h expected %h", got, exp);
    abort_run();
  end
endtask

//============================================================
//  stimulus
//============================================================
// random issue that the DUT must ignore while busy
task automatic drive_ignored_issue();
  logic [31:0] r;
  r          = next_rand();
  issue_sel  = 1'b1;
  issue_func = random_func();
  src0       = next_rand();
  src1       = next_rand();
  issue_tag  = r[18:0];
endtask

// one operation entered 2 ns after a rising edge
task automatic run_op(input fdsu_pkg::fdsu_func_t func, input logic [31:0] a,
                      input logic [31:0] b, input fdsu_pkg::fdsu_tag_t tag,
                      input int spur_at);
  fdsu_pkg::fdsu_wb_t exp;
  int                 lat;
  int                 n;
  n   = (func.width == fdsu_pkg::W_HALF) ? 16 : 32;
  exp = model_result(func, a, b, tag);
  if (busy !== 1'b0 || wb_vld !== 1'b0)
  begin
    $display("busy or wb_vld is high while the unit should be idle");
    abort_run();
  end
  if (pulses != ops_done)
  begin
    $display("%0d write-back pulses seen for %0d operations", pulses, ops_done);
    abort_run();
  end
  issue_sel  = 1'b1;
  issue_func = func;
  src0       = a;
  src1       = b;
  issue_tag  = tag;
  // edge 0 accepts the issue
  @(posedge ex1_data_clk);
  #2;
  issue_sel = 1'b0;
  lat       = 0;
  while (wb_vld !== 1'b1)
  begin
    if (busy !== 1'b1)
    begin
      $display("busy is low %0d cycles after issue while the operation runs", lat);
      abort_run();
    end
    if (lat == spur_at)
      drive_ignored_issue();
    else
      issue_sel = 1'b0;
    @(posedge ex1_data_clk);
    #2;
    lat++;
  end
  // busy is still high in the write-back cycle so this issue is dropped too
  drive_ignored_issue();
  if (busy !== 1'b1)
  begin
    $display("busy is low in the write-back cycle");
    abort_run();
  end
  if (lat != n + 3)
  begin
    $display("write-back came %0d cycles after issue, expected %0d", lat, n + 3);
    abort_run();
  end
  check_data(wb.data, exp.data);
  check_expt(wb.expt, exp.expt);
  check_tag(wb.tag, exp.tag);
  ops_done++;
  @(posedge ex1_data_clk);
  #2;
  issue_sel = 1'b0;
endtask

initial
begin
  fdsu_pkg::fdsu_func_t func;
  fdsu_pkg::fdsu_tag_t  tag;
  logic [31:0]          a;
  logic [31:0]          b;
  logic [31:0]          d;
  logic [31:0]          one;
  logic [31:0]          r;
  logic                 half;
  int                   spur;
  issue_sel  = 1'b0;
  issue_func = '0;
  src0       = '0;
  src1       = '0;
  issue_tag  = '0;
  cpurst_b   = 1'b0;
  repeat (2) @(posedge ex1_data_clk);
  #2;
  cpurst_b = 1'b1;
  // idle after reset
  repeat (3)
  begin
    @(posedge ex1_data_clk);
    #2;
    if (busy !== 1'b0 || wb_vld !== 1'b0)
    begin
      $display("busy or wb_vld is high after reset before any issue");
      abort_run();
    end
  end
  for (int i = 0; i < NUM_OPS; i++)
  begin
    func = random_func();
    a    = next_rand();
    b    = next_rand();
    r    = next_rand();
    tag  = r[31:13];
    half = (func.width == fdsu_pkg::W_HALF);
    one  = half ? 32'h0000_8000 : 32'h8000_0000;
    // divisor is src1, or src0 for a reciprocal
    d = (func.op == fdsu_pkg::OP_RECIP) ? a : b;
    if (r[2:0] == 3'd0)
      d = half ? {d[31:16], 16'h0000} : 32'h0;
    else if (r[2:0] <= 3'd4)
      d = d | one;
    if (func.op == fdsu_pkg::OP_RECIP)
      a = d;
    else
      b = d;
    // exact cases with a zero remainder
    if (r[2:0] == 3'd7)
      a = (func.op == fdsu_pkg::OP_DIV) ? b : one;
    spur = int'(r[11:4]) % ((half ? 16 : 32) + 3);
    run_op(func, a, b, tag, spur);
  end
  // one more cycle so the monitor sees any trailing write-back pulse
  @(posedge ex1_data_clk);
  #2;
  if (pulses != ops_done)
  begin
    $display("%0d write-back pulses seen for %0d operations", pulses, ops_done);
    abort_run();
  end
  else
  begin
    $display(">>> PASS");
    $finish;
  end
end

endmodule

/* compile.f */
logic/fdsu_pkg.sv
logic/fdsu_ctrl.sv
logic/fdsu_scalar_dp.sv
logic/fdsu_iter.sv
logic/fdsu_pack.sv
logic/fdsu_top.sv
verification/tb_fdsu.sv

/* run_sim.sh */
#!/bin/sh
# build tb_fdsu with Verilator, run it, and judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_fdsu \
  -f compile.f -o tb_fdsu || { echo "build failed"; exit 1; }
./obj_dir/tb_fdsu > sim.log 2>&1
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "simulation reported an error"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation finished cleanly"
